/* logic/chip_ctrl_pkg.sv */
/*
 * Chip control shared definitions
 * APB config port types, address map, clock and pad configuration encodings
 */

package chip_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////////
  localparam int unsigned APB_ADDR_W = 12;
  localparam int unsigned APB_DATA_W = 32;

  typedef logic [APB_ADDR_W-1:0] apb_addr_t;
  typedef logic [APB_DATA_W-1:0] apb_data_t;

  //////////////////////////////////////////////////////////////////////////
  // Address map
  //////////////////////////////////////////////////////////////////////////
  // Each region spans 256 bytes, upper address bits pick the region
  localparam int unsigned REGION_OFS_W = 8;
  localparam apb_addr_t CLK_REGION_BASE = 12'h000;
  localparam apb_addr_t PAD_REGION_BASE = 12'h100;
  // Single clock register sits at the bottom of its region
  localparam apb_addr_t CLK_REG_OFFSET = 12'h000;

  // Word index of a pad register, address bits 7 down to 2
  localparam int unsigned PAD_IDX_LSB = 2;
  localparam int unsigned PAD_IDX_W = 6;
  typedef logic [PAD_IDX_W-1:0] pad_idx_t;

  //////////////////////////////////////////////////////////////////////////
  // APB request and response
  //////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
  } apb_req_t;

  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // Target of a decoded access
  typedef enum logic [1:0] {
    REGION_CLK = 2'd0,
    REGION_PAD = 2'd1,
    REGION_ERR = 2'd2
  } region_e;

  //////////////////////////////////////////////////////////////////////////
  // Clock and pad configuration
  //////////////////////////////////////////////////////////////////////////
  // Enable in the low bit, so all-enabled reads back as 0x15
  typedef struct packed {
    logic byp;
    logic en;
  } clk_dom_cfg_t;

  typedef struct packed {
    clk_dom_cfg_t per;
    clk_dom_cfg_t soc;
    clk_dom_cfg_t slow;
  } clk_cfg_t;

  // Encoding 3 has no name and behaves as input only
  typedef enum logic [1:0] {
    PAD_GPIO  = 2'd0,
    PAD_TIMER = 2'd1,
    PAD_INPUT = 2'd2
  } pad_func_e;

  // All domains running from their own source after reset
  localparam clk_cfg_t CLK_CFG_RESET = '{
    per:  '{byp: 1'b0, en: 1'b1},
    soc:  '{byp: 1'b0, en: 1'b1},
    slow: '{byp: 1'b0, en: 1'b1}
  };

endpackage

/* logic/chip_ctrl_decode.sv */
/*
 * Chip control address decoder
 * Splits the config address into clock, pad and error regions
 */

`timescale 1ns/1ps

module chip_ctrl_decode
  import chip_ctrl_pkg::*;
#(
  parameter int unsigned PAD_COUNT = 8
) (
  input  apb_addr_t paddr_i,
  output region_e   region_o,
  output pad_idx_t  pad_idx_o
);

  // Region tag is everything above the in-region offset
  localparam int unsigned TAG_W = APB_ADDR_W - REGION_OFS_W;

  logic [TAG_W-1:0] addr_tag;
  logic             clk_hit;
  logic             pad_hit;
  logic             pad_in_range;

  assign addr_tag = paddr_i[APB_ADDR_W-1:REGION_OFS_W];

  // Range compares against the two mapped regions
  assign clk_hit = (addr_tag == CLK_REGION_BASE[APB_ADDR_W-1:REGION_OFS_W]);
  assign pad_hit = (addr_tag == PAD_REGION_BASE[APB_ADDR_W-1:REGION_OFS_W]);

  // Word index inside the pad region
  assign pad_idx_o = paddr_i[PAD_IDX_LSB +: PAD_IDX_W];

  // Indices past the last pad have no register behind them
  assign pad_in_range = (int'(pad_idx_o) < PAD_COUNT);

  //////////////////////////////////////////////////////////////////////////
  // Region select
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    // Default target is the error slave
    region_o = REGION_ERR;
    if (clk_hit) begin
      region_o = REGION_CLK;
    end else if (pad_hit && pad_in_range) begin
      region_o = REGION_PAD;
    end
  end

endmodule

/* logic/clk_ctrl_regs.sv */
/*
 * Clock control register
 * Enable and bypass bits of the slow, SoC and peripheral clock domains
 */

`timescale 1ns/1ps

module clk_ctrl_regs
  import chip_ctrl_pkg::*;
(
  input  logic     soc_clk_i,
  input  logic     arst_n_i,
  input  apb_req_t apb_req_i,
  input  logic     sel_i,
  input  logic     pad_clk_byp_i,
  output apb_rsp_t apb_rsp_o,
  output clk_cfg_t clk_cfg_o
);

  localparam int unsigned CFG_W = $bits(clk_cfg_t);

  clk_cfg_t cfg_q;
  logic     access;
  logic     reg_hit;
  logic     wr_en;
  logic     rd_en;

  //////////////////////////////////////////////////////////////////////////
  // Access qualification
  //////////////////////////////////////////////////////////////////////////
  // Access phase of a transfer aimed at this region
  assign access = sel_i && apb_req_i.psel && apb_req_i.penable;

  // Only word offset 0 holds a register, low byte lanes ignored
  assign reg_hit = (apb_req_i.paddr[REGION_OFS_W-1:2] ==
                    CLK_REG_OFFSET[REGION_OFS_W-1:2]);

  assign wr_en = access && apb_req_i.pwrite && reg_hit;
  assign rd_en = access && !apb_req_i.pwrite && reg_hit;

  //////////////////////////////////////////////////////////////////////////
  // Configuration register
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q <= CLK_CFG_RESET;
    end else if (wr_en) begin
      // Takes effect at the edge closing the access cycle
      cfg_q <= clk_cfg_t'(apb_req_i.pwdata[CFG_W-1:0]);
    end
  end

  // Pad bypass forces every domain onto the reference clock
  always_comb begin
    clk_cfg_o = cfg_q;
    clk_cfg_o.slow.byp = cfg_q.slow.byp | pad_clk_byp_i;
    clk_cfg_o.soc.byp  = cfg_q.soc.byp  | pad_clk_byp_i;
    clk_cfg_o.per.byp  = cfg_q.per.byp  | pad_clk_byp_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // APB response
  //////////////////////////////////////////////////////////////////////////
  // No wait states, never an error from inside the region
  assign apb_rsp_o.pready  = apb_req_i.psel && apb_req_i.penable;
  assign apb_rsp_o.pslverr = 1'b0;

  // Stored value only, the pad bypass is not visible here
  assign apb_rsp_o.prdata = rd_en ? {{(APB_DATA_W-CFG_W){1'b0}}, cfg_q} : '0;

endmodule

/* logic/pad_mux_regs.sv */
/*
 * Pad multiplexer
 * Per-pad function registers selecting GPIO, timer PWM or input only
 */

`timescale 1ns/1ps

module pad_mux_regs
  import chip_ctrl_pkg::*;
#(
  parameter int unsigned PAD_COUNT = 8
) (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  input  apb_req_t             apb_req_i,
  input  logic                 sel_i,
  input  pad_idx_t             pad_idx_i,
  input  logic [PAD_COUNT-1:0] gpio_out_i,
  input  logic [PAD_COUNT-1:0] gpio_oe_i,
  input  logic [PAD_COUNT-1:0] timer_ch_i,
  input  logic [PAD_COUNT-1:0] pad_in_i,
  output apb_rsp_t             apb_rsp_o,
  output logic [PAD_COUNT-1:0] pad_out_o,
  output logic [PAD_COUNT-1:0] pad_oe_o,
  output logic [PAD_COUNT-1:0] gpio_in_o
);

  localparam int unsigned FUNC_W = $bits(pad_func_e);

  pad_func_e func_q [PAD_COUNT];
  pad_func_e rd_func;
  logic      access;
  logic      wr_en;
  logic      rd_en;

  // Access phase of a transfer aimed at this region
  assign access = sel_i && apb_req_i.psel && apb_req_i.penable;
  assign wr_en  = access && apb_req_i.pwrite;
  assign rd_en  = access && !apb_req_i.pwrite;

  //////////////////////////////////////////////////////////////////////////
  // Function registers
  //////////////////////////////////////////////////////////////////////////
  // Pads come up as inputs so nothing is driven before software runs
  always_ff @(posedge soc_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < PAD_COUNT; i++) begin
        func_q[i] <= PAD_INPUT;
      end
    end else if (wr_en) begin
      for (int i = 0; i < PAD_COUNT; i++) begin
        if (pad_idx_i == PAD_IDX_W'(i)) begin
          func_q[i] <= pad_func_e'(apb_req_i.pwdata[FUNC_W-1:0]);
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Output multiplexer
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int i = 0; i < PAD_COUNT; i++) begin
      case (func_q[i])
        PAD_GPIO: begin
          pad_out_o[i] = gpio_out_i[i];
          pad_oe_o[i]  = gpio_oe_i[i];
        end
        PAD_TIMER: begin
          // PWM channel always drives its pad
          pad_out_o[i] = timer_ch_i[i];
          pad_oe_o[i]  = 1'b1;
        end
        default: begin
          // Input only, covers the unnamed encoding too
          pad_out_o[i] = 1'b0;
          pad_oe_o[i]  = 1'b0;
        end
      endcase
    end
  end

  // Inputs return to the GPIO block regardless of the pad function
  assign gpio_in_o = pad_in_i;

  //////////////////////////////////////////////////////////////////////////
  // APB response
  //////////////////////////////////////////////////////////////////////////
  // Read mux over the function registers
  always_comb begin
    rd_func = PAD_INPUT;
    for (int i = 0; i < PAD_COUNT; i++) begin
      if (pad_idx_i == PAD_IDX_W'(i)) begin
        rd_func = func_q[i];
      end
    end
  end

  assign apb_rsp_o.pready  = apb_req_i.psel && apb_req_i.penable;
  assign apb_rsp_o.pslverr = 1'b0;
  assign apb_rsp_o.prdata  = rd_en ? {{(APB_DATA_W-FUNC_W){1'b0}}, rd_func} : '0;

endmodule

/* logic/chip_ctrl_resp.sv */
/*
 * Chip control response multiplexer
 * Forwards the addressed region's APB response, or answers as error slave
 */

`timescale 1ns/1ps

module chip_ctrl_resp
  import chip_ctrl_pkg::*;
(
  input  region_e  region_i,
  input  logic     penable_i,
  input  apb_rsp_t clk_rsp_i,
  input  apb_rsp_t pad_rsp_i,
  output apb_rsp_t apb_rsp_o
);

  apb_rsp_t err_rsp;

  //////////////////////////////////////////////////////////////////////////
  // Error slave
  //////////////////////////////////////////////////////////////////////////
  // Completes at once in the access cycle with an error flag
  always_comb begin
    err_rsp.prdata  = '0;
    err_rsp.pready  = penable_i;
    err_rsp.pslverr = penable_i;
  end

  //////////////////////////////////////////////////////////////////////////
  // Response select
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    case (region_i)
      REGION_CLK: begin
        apb_rsp_o = clk_rsp_i;
      end
      REGION_PAD: begin
        apb_rsp_o = pad_rsp_i;
      end
      default: begin
        // Unmapped or out-of-range pad address
        apb_rsp_o = err_rsp;
      end
    endcase
  end

endmodule

/* logic/chip_ctrl_top.sv */
/*
 * Chip control top level
 * APB config port split over clock control, pad mux and an error slave
 */

`timescale 1ns/1ps

module chip_ctrl_top
  import chip_ctrl_pkg::*;
#(
  parameter int unsigned PAD_COUNT = 8
) (
  input  logic                 soc_clk_i,
  input  logic                 arst_n_i,
  // Config port
  input  apb_req_t             apb_req_i,
  output apb_rsp_t             apb_rsp_o,
  // Clock control
  input  logic                 pad_clk_byp_i,
  output clk_cfg_t             clk_cfg_o,
  // Pad sources and pads
  input  logic [PAD_COUNT-1:0] gpio_out_i,
  input  logic [PAD_COUNT-1:0] gpio_oe_i,
  input  logic [PAD_COUNT-1:0] timer_ch_i,
  input  logic [PAD_COUNT-1:0] pad_in_i,
  output logic [PAD_COUNT-1:0] pad_out_o,
  output logic [PAD_COUNT-1:0] pad_oe_o,
  output logic [PAD_COUNT-1:0] gpio_in_o
);

  region_e  region;
  pad_idx_t pad_idx;
  logic     clk_sel;
  logic     pad_sel;
  apb_rsp_t clk_rsp;
  apb_rsp_t pad_rsp;

  //////////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////////
  chip_ctrl_decode #(
    .PAD_COUNT ( PAD_COUNT )
  ) chip_ctrl_decode_i (
    .paddr_i   ( apb_req_i.paddr ),
    .region_o  ( region          ),
    .pad_idx_o ( pad_idx         )
  );

  // One select per register executor
  assign clk_sel = (region == REGION_CLK);
  assign pad_sel = (region == REGION_PAD);

  //////////////////////////////////////////////////////////////////////////
  // Register executors
  //////////////////////////////////////////////////////////////////////////
  clk_ctrl_regs clk_ctrl_regs_i (
    .soc_clk_i     ( soc_clk_i     ),
    .arst_n_i      ( arst_n_i      ),
    .apb_req_i     ( apb_req_i     ),
    .sel_i         ( clk_sel       ),
    .pad_clk_byp_i ( pad_clk_byp_i ),
    .apb_rsp_o     ( clk_rsp       ),
    .clk_cfg_o     ( clk_cfg_o     )
  );

  pad_mux_regs #(
    .PAD_COUNT ( PAD_COUNT )
  ) pad_mux_regs_i (
    .soc_clk_i  ( soc_clk_i  ),
    .arst_n_i   ( arst_n_i   ),
    .apb_req_i  ( apb_req_i  ),
    .sel_i      ( pad_sel    ),
    .pad_idx_i  ( pad_idx    ),
    .gpio_out_i ( gpio_out_i ),
    .gpio_oe_i  ( gpio_oe_i  ),
    .timer_ch_i ( timer_ch_i ),
    .pad_in_i   ( pad_in_i   ),
    .apb_rsp_o  ( pad_rsp    ),
    .pad_out_o  ( pad_out_o  ),
    .pad_oe_o   ( pad_oe_o   ),
    .gpio_in_o  ( gpio_in_o  )
  );

  //////////////////////////////////////////////////////////////////////////
  // Response mux
  //////////////////////////////////////////////////////////////////////////
  chip_ctrl_resp chip_ctrl_resp_i (
    .region_i  ( region            ),
    .penable_i ( apb_req_i.penable ),
    .clk_rsp_i ( clk_rsp           ),
    .pad_rsp_i ( pad_rsp           ),
    .apb_rsp_o ( apb_rsp_o         )
  );

endmodule

/* verif/chip_ctrl_tb.sv */
/*
 * Chip control testbench
 * APB driver, pad stimulus and checks of clock, pad mux and error slave
 */

`timescale 1ns/1ps

module chip_ctrl_tb
  import chip_ctrl_pkg::*;
();

  localparam int unsigned PADS = 8;

  logic            soc_clk;
  logic            arst_n;
  apb_req_t        apb_req;
  apb_rsp_t        apb_rsp;
  logic            pad_clk_byp;
  clk_cfg_t        clk_cfg;
  logic [PADS-1:0] gpio_out;
  logic [PADS-1:0] gpio_oe;
  logic [PADS-1:0] timer_ch;
  logic [PADS-1:0] pad_in;
  logic [PADS-1:0] pad_out;
  logic [PADS-1:0] pad_oe;
  logic [PADS-1:0] gpio_in;

  // Expected function code per pad
  logic [1:0]      pad_model [PADS];
  int              n_checks;
  int              n_errors;

  chip_ctrl_top #(
    .PAD_COUNT ( PADS )
  ) chip_ctrl_top_i (
    .soc_clk_i     ( soc_clk     ),
    .arst_n_i      ( arst_n      ),
    .apb_req_i     ( apb_req     ),
    .apb_rsp_o     ( apb_rsp     ),
    .pad_clk_byp_i ( pad_clk_byp ),
    .clk_cfg_o     ( clk_cfg     ),
    .gpio_out_i    ( gpio_out    ),
    .gpio_oe_i     ( gpio_oe     ),
    .timer_ch_i    ( timer_ch    ),
    .pad_in_i      ( pad_in      ),
    .pad_out_o     ( pad_out     ),
    .pad_oe_o      ( pad_oe      ),
    .gpio_in_o     ( gpio_in     )
  );

  // 20 ns SoC clock
  initial begin
    soc_clk = 1'b0;
    forever #10 soc_clk = ~soc_clk;
  end

  //////////////////////////////////////////////////////////////////////////
  // Checking and APB driver
  //////////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    n_checks++;
    assert (act === exp) else begin
      n_errors++;
      $display("Fail %s expected 0x%0h actual 0x%0h", name, exp, act);
    end
  endtask

  // Setup cycle, then access cycle until pready, bounded to 10 cycles
  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            input logic exp_err, input logic chk_rd, input apb_data_t exp_rd);
    int wait_cycles;
    @(posedge soc_clk);
    #2;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge soc_clk);
    #2;
    apb_req.penable = 1'b1;
    #1;
    // No wait states, pready is due in the first access cycle
    check_value("pready", 32'd1, 32'(apb_rsp.pready));
    wait_cycles = 0;
    while (!apb_rsp.pready && wait_cycles < 10) begin
      @(posedge soc_clk);
      #3;
      wait_cycles++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer to address 0x%03h got no pready within 10 cycles", addr);
      $display("Checks failed");
      $finish;
    end else begin
      check_value("pslverr", 32'(exp_err), 32'(apb_rsp.pslverr));
      // Error slave always returns zero data
      if (chk_rd || exp_err) begin
        check_value("prdata", exp_err ? 32'd0 : exp_rd, apb_rsp.prdata);
      end
      // Access edge, write lands here
      @(posedge soc_clk);
      #2;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
    end
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
    apb_access(1'b1, addr, data, exp_err, 1'b0, '0);
  endtask

  task automatic apb_read(input apb_addr_t addr, input apb_data_t exp, input logic exp_err);
    apb_access(1'b0, addr, '0, exp_err, 1'b1, exp);
  endtask

  // New random GPIO and timer sources, driven after the edge
  task automatic drive_sources();
    @(posedge soc_clk);
    #2;
    gpio_out = PADS'($urandom());
    gpio_oe  = PADS'($urandom());
    timer_ch = PADS'($urandom());
    #1;
  endtask

  // Pad outputs against the mux rule applied to the model
  task automatic check_pads();
    logic [PADS-1:0] exp_out;
    logic [PADS-1:0] exp_oe;
    for (int i = 0; i < PADS; i++) begin
      case (pad_model[i])
        2'd0: begin
          exp_out[i] = gpio_out[i];
          exp_oe[i]  = gpio_oe[i];
        end
        2'd1: begin
          exp_out[i] = timer_ch[i];
          exp_oe[i]  = 1'b1;
        end
        default: begin
          exp_out[i] = 1'b0;
          exp_oe[i]  = 1'b0;
        end
      endcase
    end
    check_value("pad_out_o", 32'(exp_out), 32'(pad_out));
    check_value("pad_oe_o", 32'(exp_oe), 32'(pad_oe));
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, n_errors - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////////
  task automatic test_reset();
    int errs;
    errs = n_errors;
    // All three enables set, bypass clear
    check_value("clk_cfg_o", 32'h15, 32'(clk_cfg));
    check_value("pad_oe_o", 32'h0, 32'(pad_oe));
    check_value("pad_out_o", 32'h0, 32'(pad_out));
    // Idle bus
    check_value("pready", 32'd0, 32'(apb_rsp.pready));
    check_value("pslverr", 32'd0, 32'(apb_rsp.pslverr));
    apb_read(12'h000, 32'h15, 1'b0);
    report_test("reset values", errs);
  endtask

  task automatic test_clk_reg();
    int errs;
    logic [5:0] val;
    errs = n_errors;
    for (int n = 0; n < 8; n++) begin
      val = 6'($urandom());
      apb_write(12'h000, 32'(val), 1'b0);
      check_value("clk_cfg_o", 32'(val), 32'(clk_cfg));
      apb_read(12'h000, 32'(val), 1'b0);
      // Pad bypass sets bits 1, 3 and 5 on the output only
      pad_clk_byp = 1'b1;
      #1;
      check_value("clk_cfg_o", 32'(val | 6'h2a), 32'(clk_cfg));
      apb_read(12'h000, 32'(val), 1'b0);
      pad_clk_byp = 1'b0;
      // Unused offset reads zero and keeps the register
      apb_write(12'h004, 32'hffff_ffff, 1'b0);
      apb_read(12'h004, 32'h0, 1'b0);
      check_value("clk_cfg_o", 32'(val), 32'(clk_cfg));
    end
    report_test("clock register", errs);
  endtask

  task automatic test_pad_mux();
    int errs;
    logic [1:0] func;
    errs = n_errors;
    for (int r = 0; r < 3; r++) begin
      for (int i = 0; i < PADS; i++) begin
        // Rotate GPIO, timer and input over the pads
        func = 2'((i + r) % 3);
        apb_write(12'h100 + 12'(4 * i), 32'(func), 1'b0);
        pad_model[i] = func;
      end
      for (int k = 0; k < 4; k++) begin
        drive_sources();
        check_pads();
      end
      for (int i = 0; i < PADS; i++) begin
        apb_read(12'h100 + 12'(4 * i), 32'(pad_model[i]), 1'b0);
      end
    end
    report_test("pad multiplexer", errs);
  endtask

  task automatic test_pad_in();
    int errs;
    errs = n_errors;
    for (int n = 0; n < 16; n++) begin
      @(posedge soc_clk);
      #2;
      pad_in = PADS'($urandom());
      // Combinational path, same cycle
      #1;
      check_value("gpio_in_o", 32'(pad_in), 32'(gpio_in));
    end
    report_test("pad inputs", errs);
  endtask

  task automatic test_err_slave();
    int errs;
    clk_cfg_t        cfg_before;
    logic [PADS-1:0] out_before;
    logic [PADS-1:0] oe_before;
    errs = n_errors;
    drive_sources();
    cfg_before = clk_cfg;
    out_before = pad_out;
    oe_before  = pad_oe;
    // Unmapped regions
    apb_write(12'h200, 32'hffff_ffff, 1'b1);
    apb_read(12'h200, 32'h0, 1'b1);
    apb_write(12'hffc, 32'h0, 1'b1);
    // Pad indices 8 and up
    apb_write(12'h120, 32'h0, 1'b1);
    apb_read(12'h120, 32'h0, 1'b1);
    apb_write(12'h1fc, 32'h1, 1'b1);
    apb_read(12'h1fc, 32'h0, 1'b1);
    check_value("clk_cfg_o", 32'(cfg_before), 32'(clk_cfg));
    check_value("pad_out_o", 32'(out_before), 32'(pad_out));
    check_value("pad_oe_o", 32'(oe_before), 32'(pad_oe));
    report_test("error slave", errs);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(32'h44f5_e448));
    n_checks    = 0;
    n_errors    = 0;
    arst_n      = 1'b0;
    apb_req     = '0;
    pad_clk_byp = 1'b0;
    // All sources high, so a pad not in input mode would drive after reset
    gpio_out    = '1;
    gpio_oe     = '1;
    timer_ch    = '1;
    pad_in      = '0;
    for (int i = 0; i < PADS; i++) begin
      pad_model[i] = 2'd2;
    end
    repeat (4) @(posedge soc_clk);
    #2;
    arst_n = 1'b1;
    #1;
    test_reset();
    test_clk_reg();
    test_pad_mux();
    test_pad_in();
    test_err_slave();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* chip_ctrl.f */
logic/chip_ctrl_pkg.sv
logic/chip_ctrl_decode.sv
logic/clk_ctrl_regs.sv
logic/pad_mux_regs.sv
logic/chip_ctrl_resp.sv
logic/chip_ctrl_top.sv
verif/chip_ctrl_tb.sv

/* Bender.yml */
package:
  name: chip_ctrl

sources:
  - logic/chip_ctrl_pkg.sv
  - logic/chip_ctrl_decode.sv
  - logic/clk_ctrl_regs.sv
  - logic/pad_mux_regs.sv
  - logic/chip_ctrl_resp.sv
  - logic/chip_ctrl_top.sv
  - target: test
    files:
      - verif/chip_ctrl_tb.sv
